//--- common/rv_core_pkg.sv
package rv_core_pkg;

	// fixed by the RV32I instruction set
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	// decoder to execute unit, 110 bits
	typedef struct packed {
		alu_op_e  alu_op;
		mem_op_e  mem_op;
		logic     branch;
		// invert the equality compare (bne)
		logic     branch_ne;
		logic     use_imm;
		reg_idx_t rd;
		logic     reg_we;
		word_t    imm;
		word_t    rs1_data;
		word_t    rs2_data;
	} decoded_t;

endpackage

//--- common/exec_if.sv
`timescale 1ns/100ps

interface exec_if;

	// one-cycle pulse per executed instruction
	logic                  valid;
	rv_core_pkg::mem_op_e  mem_op;
	rv_core_pkg::reg_idx_t rd;
	logic                  reg_we;
	// alu result, or the byte address for lw/sw
	rv_core_pkg::word_t    result;
	rv_core_pkg::word_t    store_data;

	modport source (
		output valid,
		output mem_op,
		output rd,
		output reg_we,
		output result,
		output store_data
	);

	modport sink (
		input valid,
		input mem_op,
		input rd,
		input reg_we,
		input result,
		input store_data
	);

endinterface

//--- hw/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
	parameter rv_core_pkg::addr_t RESET_PC = '0
) (
	input  logic               clock,
	input  logic               arst_n_i,
	output rv_core_pkg::addr_t imem_addr_o,
	output logic               imem_valid_o,
	input  logic               imem_ready_i,
	input  logic               imem_rvalid_i,
	input  rv_core_pkg::word_t imem_rdata_i,
	input  logic               branch_taken_i,
	input  rv_core_pkg::addr_t branch_target_i,
	input  logic               retire_i,
	output rv_core_pkg::word_t inst_o,
	output rv_core_pkg::addr_t pc_o,
	output logic               issue_o
);

	typedef enum logic [1:0] {
		REQUEST,
		WAIT_RESPONSE,
		ISSUE,
		WAIT_RETIRE
	} fetch_state_e;

	fetch_state_e       state_q;
	logic               req_valid_q;
	logic               issued_q;
	rv_core_pkg::addr_t pc_q;
	rv_core_pkg::addr_t next_pc_q;
	rv_core_pkg::word_t inst_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= REQUEST;
			req_valid_q <= 1'b0;
			issued_q    <= 1'b0;
			pc_q        <= RESET_PC;
		end else begin
			issued_q <= (state_q == ISSUE);
			case (state_q)
				REQUEST: begin
					// first request after reset raises valid here
					if (!req_valid_q) begin
						req_valid_q <= 1'b1;
					end else if (imem_ready_i) begin
						req_valid_q <= 1'b0;
						state_q     <= WAIT_RESPONSE;
					end
				end
				WAIT_RESPONSE: begin
					if (imem_rvalid_i) begin
						state_q <= ISSUE;
					end
				end
				ISSUE: begin
					state_q <= WAIT_RETIRE;
				end
				WAIT_RETIRE: begin
					if (retire_i) begin
						pc_q        <= next_pc_q;
						req_valid_q <= 1'b1;
						state_q     <= REQUEST;
					end
				end
				default: state_q <= REQUEST;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == WAIT_RESPONSE && imem_rvalid_i) begin
			inst_q <= imem_rdata_i;
		end
		// redirect from execute is valid one cycle after issue
		if (issued_q) begin
			next_pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
		end
	end

	assign imem_addr_o  = pc_q;
	assign imem_valid_o = req_valid_q;
	assign inst_o       = inst_q;
	assign pc_o         = pc_q;
	assign issue_o      = (state_q == ISSUE);

	// stalled fetch keeps its address
	assert property (@(posedge clock) disable iff (!arst_n_i)
		imem_valid_o && !imem_ready_i |=> imem_valid_o && $stable(imem_addr_o))
		else $error("fetch address changed while waiting for ready");

endmodule

//--- hw/core/decoder.sv
`timescale 1ns/100ps

module decoder (
	input  rv_core_pkg::word_t    inst_i,
	input  rv_core_pkg::word_t    rs1_data_i,
	input  rv_core_pkg::word_t    rs2_data_i,
	output rv_core_pkg::reg_idx_t rs1_idx_o,
	output rv_core_pkg::reg_idx_t rs2_idx_o,
	output rv_core_pkg::decoded_t dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode    = inst_i[6:0];
	assign funct3    = inst_i[14:12];
	assign funct7    = inst_i[31:25];
	assign rs1_idx_o = inst_i[19:15];
	assign rs2_idx_o = inst_i[24:20];

	always_comb begin
		// anything not matched below retires as a no-op
		dec_o           = '0;
		dec_o.alu_op    = rv_core_pkg::ALU_ADD;
		dec_o.mem_op    = rv_core_pkg::MEM_NONE;
		dec_o.rd        = inst_i[11:7];
		dec_o.rs1_data  = rs1_data_i;
		dec_o.rs2_data  = rs2_data_i;

		case (opcode)
			rv_core_pkg::OPC_LUI: begin
				dec_o.imm     = {inst_i[31:12], 12'b0};
				dec_o.alu_op  = rv_core_pkg::ALU_PASS_B;
				dec_o.use_imm = 1'b1;
				dec_o.reg_we  = 1'b1;
			end
			rv_core_pkg::OPC_OP_IMM: begin
				dec_o.imm     = {{20{inst_i[31]}}, inst_i[31:20]};
				dec_o.use_imm = 1'b1;
				// addi only
				dec_o.reg_we  = (funct3 == 3'b000);
			end
			rv_core_pkg::OPC_OP: begin
				dec_o.reg_we = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_o.alu_op = rv_core_pkg::ALU_ADD;
					{7'b0100000, 3'b000}: dec_o.alu_op = rv_core_pkg::ALU_SUB;
					{7'b0000000, 3'b100}: dec_o.alu_op = rv_core_pkg::ALU_XOR;
					{7'b0000000, 3'b110}: dec_o.alu_op = rv_core_pkg::ALU_OR;
					{7'b0000000, 3'b111}: dec_o.alu_op = rv_core_pkg::ALU_AND;
					default: dec_o.reg_we = 1'b0;
				endcase
			end
			rv_core_pkg::OPC_BRANCH: begin
				dec_o.imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
					inst_i[30:25], inst_i[11:8], 1'b0};
				// beq and bne, other compares fall through as no-ops
				dec_o.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
				dec_o.branch_ne = (funct3 == 3'b001);
			end
			rv_core_pkg::OPC_LOAD: begin
				dec_o.imm     = {{20{inst_i[31]}}, inst_i[31:20]};
				dec_o.use_imm = 1'b1;
				if (funct3 == 3'b010) begin
					dec_o.mem_op = rv_core_pkg::MEM_LOAD;
					dec_o.reg_we = 1'b1;
				end
			end
			rv_core_pkg::OPC_STORE: begin
				dec_o.imm     = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
				dec_o.use_imm = 1'b1;
				if (funct3 == 3'b010) begin
					dec_o.mem_op = rv_core_pkg::MEM_STORE;
				end
			end
			default: begin
				dec_o.reg_we = 1'b0;
			end
		endcase
	end

endmodule

//--- hw/core/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic                  clock,
	input  logic                  arst_n_i,
	input  rv_core_pkg::reg_idx_t rs1_idx_i,
	input  rv_core_pkg::reg_idx_t rs2_idx_i,
	input  logic                  we_i,
	input  rv_core_pkg::reg_idx_t waddr_i,
	input  rv_core_pkg::word_t    wdata_i,
	output rv_core_pkg::word_t    rs1_data_o,
	output rv_core_pkg::word_t    rs2_data_o
);

	// x1..x31, x0 has no storage
	rv_core_pkg::word_t regs_q [1:31];

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs_q[rs1_idx_i];
	assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs_q[rs2_idx_i];

	assert property (@(posedge clock) disable iff (!arst_n_i)
		we_i |-> !$isunknown(waddr_i))
		else $error("register write with unknown address");

endmodule

//--- hw/core/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
	input  logic                  clock,
	input  logic                  arst_n_i,
	input  logic                  issue_i,
	input  rv_core_pkg::addr_t    pc_i,
	input  rv_core_pkg::decoded_t dec_i,
	output logic                  branch_taken_o,
	output rv_core_pkg::addr_t    branch_target_o,
	exec_if.source                ex
);

	rv_core_pkg::word_t operand_b;
	rv_core_pkg::word_t alu_result;
	logic               rs_equal;

	assign operand_b = dec_i.use_imm ? dec_i.imm : dec_i.rs2_data;
	assign rs_equal  = (dec_i.rs1_data == dec_i.rs2_data);

	// add also forms the lw/sw address
	always_comb begin
		case (dec_i.alu_op)
			rv_core_pkg::ALU_ADD:    alu_result = dec_i.rs1_data + operand_b;
			rv_core_pkg::ALU_SUB:    alu_result = dec_i.rs1_data - operand_b;
			rv_core_pkg::ALU_AND:    alu_result = dec_i.rs1_data & operand_b;
			rv_core_pkg::ALU_OR:     alu_result = dec_i.rs1_data | operand_b;
			rv_core_pkg::ALU_XOR:    alu_result = dec_i.rs1_data ^ operand_b;
			rv_core_pkg::ALU_PASS_B: alu_result = operand_b;
			default:                 alu_result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex.valid       <= 1'b0;
			ex.mem_op      <= rv_core_pkg::MEM_NONE;
			ex.reg_we      <= 1'b0;
			branch_taken_o <= 1'b0;
		end else begin
			ex.valid <= issue_i;
			if (issue_i) begin
				ex.mem_op      <= dec_i.mem_op;
				ex.reg_we      <= dec_i.reg_we;
				branch_taken_o <= dec_i.branch && (rs_equal ^ dec_i.branch_ne);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue_i) begin
			ex.rd           <= dec_i.rd;
			ex.result       <= alu_result;
			ex.store_data   <= dec_i.rs2_data;
			branch_target_o <= pc_i + dec_i.imm;
		end
	end

endmodule

//--- hw/lsu_unit.sv
`timescale 1ns/100ps

module lsu_unit (
	input  logic                  clock,
	input  logic                  arst_n_i,
	output rv_core_pkg::addr_t    dmem_addr_o,
	output logic                  dmem_we_o,
	output rv_core_pkg::word_t    dmem_wdata_o,
	output logic                  dmem_valid_o,
	input  logic                  dmem_ready_i,
	input  logic                  dmem_rvalid_i,
	input  rv_core_pkg::word_t    dmem_rdata_i,
	output logic                  rf_we_o,
	output rv_core_pkg::reg_idx_t rf_waddr_o,
	output rv_core_pkg::word_t    rf_wdata_o,
	output logic                  retire_o,
	exec_if.sink                  ex
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_RESPONSE
	} lsu_state_e;

	lsu_state_e            state_q;
	rv_core_pkg::addr_t    addr_q;
	logic                  we_q;
	rv_core_pkg::word_t    wdata_q;
	logic                  reg_we_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= IDLE;
			rf_we_o  <= 1'b0;
			retire_o <= 1'b0;
		end else begin
			rf_we_o  <= 1'b0;
			retire_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (ex.valid && ex.mem_op == rv_core_pkg::MEM_NONE) begin
						rf_we_o  <= ex.reg_we;
						retire_o <= 1'b1;
					end else if (ex.valid) begin
						state_q <= REQUEST;
					end
				end
				REQUEST: begin
					if (dmem_ready_i) begin
						state_q <= WAIT_RESPONSE;
					end
				end
				WAIT_RESPONSE: begin
					// store response only acknowledges, reg_we_q is low then
					if (dmem_rvalid_i) begin
						rf_we_o  <= reg_we_q;
						retire_o <= 1'b1;
						state_q  <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// request and writeback payload, rf_waddr_o holds rd until the load returns
	always_ff @(posedge clock) begin
		if (state_q == IDLE && ex.valid) begin
			addr_q     <= ex.result;
			we_q       <= (ex.mem_op == rv_core_pkg::MEM_STORE);
			wdata_q    <= ex.store_data;
			reg_we_q   <= ex.reg_we;
			rf_waddr_o <= ex.rd;
			rf_wdata_o <= ex.result;
		end else if (state_q == WAIT_RESPONSE && dmem_rvalid_i) begin
			rf_wdata_o <= dmem_rdata_i;
		end
	end

	assign dmem_valid_o = (state_q == REQUEST);
	assign dmem_addr_o  = addr_q;
	assign dmem_we_o    = we_q;
	assign dmem_wdata_o = wdata_q;

	assert property (@(posedge clock) disable iff (!arst_n_i)
		dmem_valid_o && !dmem_ready_i |=> dmem_valid_o
			&& $stable({dmem_addr_o, dmem_we_o, dmem_wdata_o}))
		else $error("data request changed while waiting for ready");

	// only one instruction in flight
	assert property (@(posedge clock) disable iff (!arst_n_i)
		ex.valid |-> state_q == IDLE)
		else $error("executed instruction arrived while lsu busy");

endmodule

//--- hw/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top #(
	parameter rv_core_pkg::addr_t RESET_PC = '0
) (
	input  logic               clock,
	input  logic               arst_n_i,
	// instruction port
	output rv_core_pkg::addr_t imem_addr_o,
	output logic               imem_valid_o,
	input  logic               imem_ready_i,
	input  logic               imem_rvalid_i,
	input  rv_core_pkg::word_t imem_rdata_i,
	// data port
	output rv_core_pkg::addr_t dmem_addr_o,
	output logic               dmem_we_o,
	output rv_core_pkg::word_t dmem_wdata_o,
	output logic               dmem_valid_o,
	input  logic               dmem_ready_i,
	input  logic               dmem_rvalid_i,
	input  rv_core_pkg::word_t dmem_rdata_i
);

	rv_core_pkg::word_t    inst;
	rv_core_pkg::addr_t    pc;
	logic                  issue;
	rv_core_pkg::reg_idx_t rs1_idx;
	rv_core_pkg::reg_idx_t rs2_idx;
	rv_core_pkg::word_t    rs1_data;
	rv_core_pkg::word_t    rs2_data;
	rv_core_pkg::decoded_t dec;
	logic                  branch_taken;
	rv_core_pkg::addr_t    branch_target;
	logic                  rf_we;
	rv_core_pkg::reg_idx_t rf_waddr;
	rv_core_pkg::word_t    rf_wdata;
	// lsu retire closes the instruction
	logic                  retire;

	exec_if ex_bus ();

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch_unit (
		.clock           (clock),
		.arst_n_i        (arst_n_i),
		.imem_addr_o     (imem_addr_o),
		.imem_valid_o    (imem_valid_o),
		.imem_ready_i    (imem_ready_i),
		.imem_rvalid_i   (imem_rvalid_i),
		.imem_rdata_i    (imem_rdata_i),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.retire_i        (retire),
		.inst_o          (inst),
		.pc_o            (pc),
		.issue_o         (issue)
	);

	decoder u_decoder (
		.inst_i     (inst),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.rs1_idx_o  (rs1_idx),
		.rs2_idx_o  (rs2_idx),
		.dec_o      (dec)
	);

	register_file u_register_file (
		.clock      (clock),
		.arst_n_i   (arst_n_i),
		.rs1_idx_i  (rs1_idx),
		.rs2_idx_i  (rs2_idx),
		.we_i       (rf_we),
		.waddr_i    (rf_waddr),
		.wdata_i    (rf_wdata),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	execute_unit u_execute_unit (
		.clock           (clock),
		.arst_n_i        (arst_n_i),
		.issue_i         (issue),
		.pc_i            (pc),
		.dec_i           (dec),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target),
		.ex              (ex_bus.source)
	);

	lsu_unit u_lsu_unit (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.dmem_addr_o   (dmem_addr_o),
		.dmem_we_o     (dmem_we_o),
		.dmem_wdata_o  (dmem_wdata_o),
		.dmem_valid_o  (dmem_valid_o),
		.dmem_ready_i  (dmem_ready_i),
		.dmem_rvalid_i (dmem_rvalid_i),
		.dmem_rdata_i  (dmem_rdata_i),
		.rf_we_o       (rf_we),
		.rf_waddr_o    (rf_waddr),
		.rf_wdata_o    (rf_wdata),
		.retire_o      (retire),
		.ex            (ex_bus.sink)
	);

endmodule

//--- verification/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural state of the reference model
rv_core_pkg::word_t model_regs [32];
rv_core_pkg::word_t model_dmem [DMEM_WORDS];

// expected traffic, in program order
rv_core_pkg::addr_t exp_fetch_q [$];
rv_core_pkg::addr_t exp_store_addr_q [$];
rv_core_pkg::word_t exp_store_data_q [$];

// runs prog from RESET_PC until the self-loop has been fetched twice
task automatic run_model();
	rv_core_pkg::addr_t pc;
	rv_core_pkg::addr_t next_pc;
	rv_core_pkg::word_t inst;
	rv_core_pkg::word_t a;
	rv_core_pkg::word_t b;
	rv_core_pkg::addr_t addr;
	logic [4:0]         rd;
	bit                 looped;
	pc = RESET_PC;
	looped = 1'b0;
	for (int r = 0; r < 32; r++) begin
		model_regs[r] = '0;
	end
	for (int i = 0; i < DMEM_WORDS; i++) begin
		model_dmem[i] = fill_word(DMEM_BASE + 4 * i);
	end
	for (int step = 0; step < MAX_STEPS; step++) begin
		exp_fetch_q.push_back(pc);
		if (looped) begin
			break;
		end
		inst = prog[pc[7:2]];
		rd = inst[11:7];
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		next_pc = pc + 32'd4;
		case (inst[6:0])
			rv_core_pkg::OPC_LUI: model_regs[rd] = {inst[31:12], 12'h000};
			rv_core_pkg::OPC_OP_IMM: model_regs[rd] = a + {{20{inst[31]}}, inst[31:20]};
			rv_core_pkg::OPC_OP: begin
				case (inst[14:12])
					3'b000: model_regs[rd] = inst[30] ? a - b : a + b;
					3'b100: model_regs[rd] = a ^ b;
					3'b110: model_regs[rd] = a | b;
					default: model_regs[rd] = a & b;
				endcase
			end
			rv_core_pkg::OPC_BRANCH: begin
				// funct3 bit 0 selects bne
				if ((a == b) != inst[12]) begin
					next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
						inst[11:8], 1'b0};
				end
			end
			rv_core_pkg::OPC_LOAD: begin
				addr = a + {{20{inst[31]}}, inst[31:20]};
				model_regs[rd] = model_dmem[addr[7:2]];
			end
			rv_core_pkg::OPC_STORE: begin
				addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				model_dmem[addr[7:2]] = b;
				exp_store_addr_q.push_back(addr);
				exp_store_data_q.push_back(b);
			end
			default: begin
			end
		endcase
		model_regs[0] = '0;
		looped = (next_pc == pc);
		pc = next_pc;
	end
endtask

`endif

//--- verification/core_tb.sv
`timescale 1ns/100ps

module core_tb;

	localparam int                 CLK_PERIOD   = 8;
	localparam int                 DRIVE_DELAY  = 1;
	localparam int                 RESET_CYCLES = 8;
	localparam int                 PROG_LEN     = 64;
	localparam int                 DMEM_WORDS   = 64;
	localparam int                 MAX_DELAY    = 3;
	localparam int                 MAX_STEPS    = 200;
	localparam int                 WORST_CYCLES = 20;
	localparam int                 WATCHDOG_NS  =
		(RESET_CYCLES + (PROG_LEN + 1) * WORST_CYCLES) * CLK_PERIOD;
	localparam logic [31:0]        SEED         = 32'h545ae08a;
	localparam rv_core_pkg::addr_t RESET_PC     = '0;
	localparam rv_core_pkg::addr_t DMEM_BASE    = 32'h100;

	logic               clock;
	logic               arst_n_i;
	rv_core_pkg::addr_t imem_addr_o;
	logic               imem_valid_o;
	logic               imem_ready_i;
	logic               imem_rvalid_i;
	rv_core_pkg::word_t imem_rdata_i;
	rv_core_pkg::addr_t dmem_addr_o;
	logic               dmem_we_o;
	rv_core_pkg::word_t dmem_wdata_o;
	logic               dmem_valid_o;
	logic               dmem_ready_i;
	logic               dmem_rvalid_i;
	rv_core_pkg::word_t dmem_rdata_i;

	rv_core_pkg::word_t prog [PROG_LEN];
	rv_core_pkg::word_t dmem [DMEM_WORDS];
	int                 errors;
	int                 checks;
	int                 fetch_seen;
	int                 fetch_total;

	rv_core_top #(
		.RESET_PC (RESET_PC)
	) dut0 (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.imem_addr_o   (imem_addr_o),
		.imem_valid_o  (imem_valid_o),
		.imem_ready_i  (imem_ready_i),
		.imem_rvalid_i (imem_rvalid_i),
		.imem_rdata_i  (imem_rdata_i),
		.dmem_addr_o   (dmem_addr_o),
		.dmem_we_o     (dmem_we_o),
		.dmem_wdata_o  (dmem_wdata_o),
		.dmem_valid_o  (dmem_valid_o),
		.dmem_ready_i  (dmem_ready_i),
		.dmem_rvalid_i (dmem_rvalid_i),
		.dmem_rdata_i  (dmem_rdata_i)
	);

	// lcg step, returns a value below n
	function automatic int unsigned draw(inout logic [31:0] state, input int unsigned n);
		state = state * 32'd1664525 + 32'd1013904223;
		return state[31:16] % n;
	endfunction

	function automatic rv_core_pkg::word_t fill_word(rv_core_pkg::addr_t a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic rv_core_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2,
		logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
	endfunction

	function automatic rv_core_pkg::word_t i_type(logic [6:0] opc, logic [4:0] rd,
		logic [2:0] f3, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_core_pkg::word_t s_type(logic [4:0] rs2, logic [4:0] rs1,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic rv_core_pkg::word_t b_type(logic [2:0] f3, logic [4:0] rs1,
		logic [4:0] rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
	endfunction

	// random program, x31 only ever holds data addresses
	task automatic build_program();
		logic [31:0] rng;
		int          idx;
		int          kind;
		int          n;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] base;
		rng = SEED;
		idx = 0;
		while (idx < PROG_LEN - 1) begin
			kind = draw(rng, 10);
			rd = 5'(draw(rng, 8));
			rs1 = 5'(draw(rng, 8));
			rs2 = 5'(draw(rng, 8));
			base = 12'(DMEM_BASE + 4 * draw(rng, 32));
			if (kind >= 8 && idx + 3 <= PROG_LEN - 1) begin
				// load, then store the loaded word one slot up
				prog[idx] = i_type(rv_core_pkg::OPC_OP_IMM, 5'd31, 3'b000, 5'd0, base);
				prog[idx + 1] = i_type(rv_core_pkg::OPC_LOAD, rd, 3'b010, 5'd31, 12'd0);
				prog[idx + 2] = s_type(rd, 5'd31, 12'd4);
				idx += 3;
			end else if (kind >= 6 && idx + 2 <= PROG_LEN - 1) begin
				prog[idx] = i_type(rv_core_pkg::OPC_OP_IMM, 5'd31, 3'b000, 5'd0, base);
				prog[idx + 1] = s_type(rs2, 5'd31, 12'd0);
				idx += 2;
			end else if (kind == 5) begin
				// forward only, never past the final self-loop
				n = 1 + draw(rng, 4);
				if (idx + n > PROG_LEN - 1) begin
					n = PROG_LEN - 1 - idx;
				end
				prog[idx] = b_type(draw(rng, 2) != 0 ? 3'b001 : 3'b000, rs1, rs2, 13'(4 * n));
				idx++;
			end else begin
				case (draw(rng, 7))
					0: prog[idx] = r_type(7'h00, rs2, rs1, 3'b000, rd);
					1: prog[idx] = r_type(7'h20, rs2, rs1, 3'b000, rd);
					2: prog[idx] = r_type(7'h00, rs2, rs1, 3'b111, rd);
					3: prog[idx] = r_type(7'h00, rs2, rs1, 3'b110, rd);
					4: prog[idx] = r_type(7'h00, rs2, rs1, 3'b100, rd);
					5: prog[idx] = i_type(rv_core_pkg::OPC_OP_IMM, rd, 3'b000, rs1,
						12'(draw(rng, 4096)));
					default: prog[idx] = {20'(draw(rng, 32'h100000)), rd, rv_core_pkg::OPC_LUI};
				endcase
				idx++;
			end
		end
		prog[PROG_LEN - 1] = b_type(3'b000, 5'd0, 5'd0, 13'd0);
	endtask

`include "core_model.svh"

	task automatic check_idle();
		checks++;
		assert (!imem_valid_o && !dmem_valid_o && !dut0.issue && !dut0.ex_bus.valid
			&& !dut0.retire && !dut0.rf_we)
		else begin
			errors++;
			$display("Error at %0t ns: a valid or enable signal is high around reset", $time);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// requests are sampled at the falling edge, responses driven after the rising edge
	initial begin : imem_responder
		logic [31:0]        rng;
		bit                 pending;
		bit                 outstanding;
		int unsigned        ready_wait;
		int unsigned        resp_wait;
		rv_core_pkg::addr_t held_addr;
		rv_core_pkg::addr_t exp_pc;
		logic               ready_n;
		logic               rvalid_n;
		rng = SEED ^ 32'h0000ffff;
		pending = 1'b0;
		outstanding = 1'b0;
		ready_wait = 0;
		resp_wait = 0;
		held_addr = '0;
		forever begin
			@(negedge clock);
			ready_n = 1'b0;
			rvalid_n = 1'b0;
			if (imem_valid_o && !pending) begin
				checks += 2;
				fetch_seen++;
				assert (!outstanding)
				else begin
					errors++;
					$display("A new fetch request came before the previous response");
				end
				assert (exp_fetch_q.size() != 0)
				else begin
					errors++;
					$display("Unexpected fetch at %h after the end of the program", imem_addr_o);
				end
				if (exp_fetch_q.size() != 0) begin
					exp_pc = exp_fetch_q.pop_front();
					checks++;
					assert (imem_addr_o == exp_pc)
					else begin
						errors++;
						$display("Error at %0t ns: fetch address %h, expected %h",
							$time, imem_addr_o, exp_pc);
					end
				end
				pending = 1'b1;
				held_addr = imem_addr_o;
				ready_wait = draw(rng, MAX_DELAY + 1);
			end else if (pending) begin
				checks++;
				assert (imem_valid_o && imem_addr_o == held_addr)
				else begin
					errors++;
					$display("Error at %0t ns: fetch request %h dropped or changed before ready",
						$time, held_addr);
				end
			end
			if (pending && imem_ready_i) begin
				pending = 1'b0;
				outstanding = 1'b1;
				resp_wait = draw(rng, MAX_DELAY + 1);
			end else if (pending) begin
				if (ready_wait == 0) begin
					ready_n = 1'b1;
				end else begin
					ready_wait--;
				end
			end
			if (outstanding) begin
				if (resp_wait == 0) begin
					rvalid_n = 1'b1;
					outstanding = 1'b0;
				end else begin
					resp_wait--;
				end
			end
			@(posedge clock);
			#DRIVE_DELAY;
			imem_ready_i = ready_n;
			imem_rvalid_i = rvalid_n;
			imem_rdata_i = rvalid_n ? prog[held_addr[7:2]] : '0;
		end
	end

	initial begin : dmem_responder
		logic [31:0]        rng;
		bit                 pending;
		bit                 outstanding;
		int unsigned        ready_wait;
		int unsigned        resp_wait;
		rv_core_pkg::addr_t held_addr;
		logic               held_we;
		rv_core_pkg::word_t held_wdata;
		rv_core_pkg::addr_t exp_addr;
		rv_core_pkg::word_t exp_data;
		logic               ready_n;
		logic               rvalid_n;
		rng = SEED ^ 32'hffff0000;
		pending = 1'b0;
		outstanding = 1'b0;
		ready_wait = 0;
		resp_wait = 0;
		held_addr = '0;
		held_we = 1'b0;
		held_wdata = '0;
		forever begin
			@(negedge clock);
			ready_n = 1'b0;
			rvalid_n = 1'b0;
			if (dmem_valid_o && !pending) begin
				checks++;
				assert (!outstanding)
				else begin
					errors++;
					$display("A new data request came before the previous response");
				end
				if (dmem_we_o) begin
					checks++;
					assert (exp_store_addr_q.size() != 0)
					else begin
						errors++;
						$display("Unexpected store to %h that the program never performs",
							dmem_addr_o);
					end
					if (exp_store_addr_q.size() != 0) begin
						exp_addr = exp_store_addr_q.pop_front();
						exp_data = exp_store_data_q.pop_front();
						checks++;
						assert (dmem_addr_o == exp_addr && dmem_wdata_o == exp_data)
						else begin
							errors++;
							$display("Error at %0t ns: store %h to %h, expected %h to %h",
								$time, dmem_wdata_o, dmem_addr_o, exp_data, exp_addr);
						end
					end
				end
				pending = 1'b1;
				held_addr = dmem_addr_o;
				held_we = dmem_we_o;
				held_wdata = dmem_wdata_o;
				ready_wait = draw(rng, MAX_DELAY + 1);
			end else if (pending) begin
				checks++;
				assert (dmem_valid_o
					&& {dmem_addr_o, dmem_we_o, dmem_wdata_o} == {held_addr, held_we, held_wdata})
				else begin
					errors++;
					$display("Error at %0t ns: data request at %h dropped or changed before ready",
						$time, held_addr);
				end
			end
			if (pending && dmem_ready_i) begin
				pending = 1'b0;
				outstanding = 1'b1;
				resp_wait = draw(rng, MAX_DELAY + 1);
				if (held_we) begin
					dmem[held_addr[7:2]] = held_wdata;
				end
			end else if (pending) begin
				if (ready_wait == 0) begin
					ready_n = 1'b1;
				end else begin
					ready_wait--;
				end
			end
			if (outstanding) begin
				if (resp_wait == 0) begin
					rvalid_n = 1'b1;
					outstanding = 1'b0;
				end else begin
					resp_wait--;
				end
			end
			@(posedge clock);
			#DRIVE_DELAY;
			dmem_ready_i = ready_n;
			dmem_rvalid_i = rvalid_n;
			dmem_rdata_i = (rvalid_n && !held_we) ? dmem[held_addr[7:2]] : '0;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the core did not reach the end of the program within %0d ns",
			WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

	initial begin : main
		arst_n_i = 1'b0;
		imem_ready_i = 1'b0;
		imem_rvalid_i = 1'b0;
		imem_rdata_i = '0;
		dmem_ready_i = 1'b0;
		dmem_rvalid_i = 1'b0;
		dmem_rdata_i = '0;
		errors = 0;
		checks = 0;
		fetch_seen = 0;
		build_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(DMEM_BASE + 4 * i);
		end
		run_model();
		fetch_total = exp_fetch_q.size();
		repeat (RESET_CYCLES - 1) @(posedge clock);
		@(negedge clock);
		check_idle();
		@(posedge clock);
		#DRIVE_DELAY;
		arst_n_i = 1'b1;
		@(negedge clock);
		check_idle();
		// last expected fetch is the second pass through the self-loop
		wait (fetch_seen == fetch_total);
		repeat (2) @(posedge clock);
		checks++;
		assert (exp_store_addr_q.size() == 0)
		else begin
			errors++;
			$display("%0d expected stores never reached the data port", exp_store_addr_q.size());
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verification
common/rv_core_pkg.sv
common/exec_if.sv
hw/fetch_unit.sv
hw/core/decoder.sv
hw/core/register_file.sv
hw/core/execute_unit.sv
hw/lsu_unit.sv
hw/rv_core_top.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - common/rv_core_pkg.sv
      - common/exec_if.sv
      - hw/fetch_unit.sv
      - hw/core/decoder.sv
      - hw/core/register_file.sv
      - hw/core/execute_unit.sv
      - hw/lsu_unit.sv
      - hw/rv_core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/core_tb.sv
